/* bench/ulpi_axis_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module ulpi_axis_properties (
  input wire                        clock,
  input wire                        areset_n,
  input wire                        stp_i,
  input wire                        dir_i,
  input wire                        s_tready_i,
  input wire                        m_tvalid_i,
  input wire                        m_tready_i,
  input wire                        m_tlast_i,
  input wire ulpi_pkg::ulpi_byte_t  m_tdata_i,
  input wire [7:0]                  bus_i
);

  int fail_count = 0;

  // Stop lasts a single cycle
  stp_single_cycle: assert property (
    @(posedge clock) disable iff (!areset_n) stp_i |=> !stp_i
  ) else begin
    fail_count++;
    $error("ulpi_stp_o stayed high for two consecutive cycles");
  end

  // No transmit beat can be taken while the PHY owns the bus
  tready_needs_bus: assert property (
    @(posedge clock) disable iff (!areset_n) dir_i |-> !s_tready_i
  ) else begin
    fail_count++;
    $error("s_axis_tready_o high while ulpi_dir_i is high");
  end

  stream_held: assert property (
    @(posedge clock) disable iff (!areset_n)
      (m_tvalid_i && !m_tready_i) |=> (m_tvalid_i && $stable(m_tdata_i) && $stable(m_tlast_i))
  ) else begin
    fail_count++;
    $error("m_axis beat changed while stalled");
  end

  // Two drivers on the bus would show up as unknown bits
  bus_released: assert property (
    @(posedge clock) disable iff (!areset_n) dir_i |-> !$isunknown(bus_i)
  ) else begin
    fail_count++;
    $error("ulpi_data_io contended while the PHY drives it");
  end

endmodule

bind ulpi_axis ulpi_axis_properties ulpi_axis_properties_inst (
  .clock      (clock),
  .areset_n   (rst_n),
  .stp_i      (ulpi_stp_o),
  .dir_i      (ulpi_dir_i),
  .s_tready_i (s_axis_tready_o),
  .m_tvalid_i (m_axis_tvalid_o),
  .m_tready_i (m_axis_tready_i),
  .m_tlast_i  (m_axis_tlast_o),
  .m_tdata_i  (m_axis_tdata_o),
  .bus_i      (ulpi_data_io)
);

`default_nettype wire

/* bench/ulpi_axis_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "ulpi_settings.svh"

module ulpi_axis_tb;

  localparam int CLK_PERIOD_NS = 4;
  localparam int BP_BYTES      = 20;

  // TX CMD for identifier nibble 1 under prefix 4'b0100
  localparam ulpi_pkg::ulpi_byte_t OUT_TXCMD = 8'h41;

  // Cycle budget of each test, summed to size the watchdog
  localparam int RESET_CYCLES    = 10;
  localparam int RX_CMD_CYCLES   = 12;
  localparam int RX_PKT_CYCLES   = 30;
  localparam int RX_BP_CYCLES    = 60;
  localparam int TX_PKT_CYCLES   = 16;
  localparam int TX_STALL_CYCLES = 40;
  localparam int TX_ABORT_CYCLES = 40;
  localparam int TOTAL_CYCLES    = RESET_CYCLES + RX_CMD_CYCLES + RX_PKT_CYCLES +
                                   RX_BP_CYCLES + TX_PKT_CYCLES + TX_STALL_CYCLES +
                                   TX_ABORT_CYCLES;

  logic                 clock;
  logic                 areset_n;
  logic                 ulpi_reset_o;
  logic                 ulpi_stp_o;
  logic                 ulpi_dir_i;
  logic                 ulpi_nxt_i;
  wire [7:0]            ulpi_data_io;
  logic                 usb_vbus_valid_o;
  logic                 usb_idle_o;
  logic                 ulpi_rx_overflow_o;
  logic                 s_axis_tvalid_i;
  logic                 s_axis_tlast_i;
  ulpi_pkg::ulpi_byte_t s_axis_tdata_i;
  logic                 s_axis_tready_o;
  logic                 m_axis_tvalid_o;
  logic                 m_axis_tlast_o;
  ulpi_pkg::ulpi_byte_t m_axis_tdata_o;
  logic                 m_axis_tready_i;

  // PHY side bus driver
  logic                 phy_drive;
  ulpi_pkg::ulpi_byte_t phy_data;

  int error_count;
  int check_total;
  int assert_failures;
  int overflow_count;
  int stp_count;
  int rx_last_count;
  int s_accept_count;

  ulpi_pkg::beat_t      rx_got [$];
  ulpi_pkg::ulpi_byte_t tx_got [$];

  assign ulpi_data_io = phy_drive ? phy_data : 8'hzz;

  ulpi_axis ulpi_axis_inst (
    .clock              (clock),
    .areset_n           (areset_n),
    .ulpi_reset_o       (ulpi_reset_o),
    .ulpi_stp_o         (ulpi_stp_o),
    .ulpi_dir_i         (ulpi_dir_i),
    .ulpi_nxt_i         (ulpi_nxt_i),
    .ulpi_data_io       (ulpi_data_io),
    .usb_vbus_valid_o   (usb_vbus_valid_o),
    .usb_idle_o         (usb_idle_o),
    .ulpi_rx_overflow_o (ulpi_rx_overflow_o),
    .s_axis_tvalid_i    (s_axis_tvalid_i),
    .s_axis_tlast_i     (s_axis_tlast_i),
    .s_axis_tdata_i     (s_axis_tdata_i),
    .s_axis_tready_o    (s_axis_tready_o),
    .m_axis_tvalid_o    (m_axis_tvalid_o),
    .m_axis_tlast_o     (m_axis_tlast_o),
    .m_axis_tdata_o     (m_axis_tdata_o),
    .m_axis_tready_i    (m_axis_tready_i)
  );

  always #(CLK_PERIOD_NS / 2) clock = ~clock;

  // Inputs change on the falling edge, so the rising edge sees settled values
  always @(posedge clock) begin : record_outputs
    ulpi_pkg::beat_t beat;
    beat.data = m_axis_tdata_o;
    beat.last = m_axis_tlast_o;
    if (m_axis_tvalid_o && m_axis_tready_i) begin
      rx_got.push_back(beat);
      if (m_axis_tlast_o) begin
        rx_last_count++;
      end
    end
    if (ulpi_rx_overflow_o) begin
      overflow_count++;
    end
    if (ulpi_stp_o) begin
      stp_count++;
    end
  end

  task automatic check_byte(input string name, input ulpi_pkg::ulpi_byte_t expected,
                            input ulpi_pkg::ulpi_byte_t actual);
    check_total++;
    if (actual !== expected) begin
      $display("FAIL %s: expected 0x%02h, actual 0x%02h", name, expected, actual);
      error_count++;
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    check_total++;
    if (actual !== expected) begin
      $display("FAIL %s: expected %b, actual %b", name, expected, actual);
      error_count++;
    end
  endtask

  task automatic check_count(input string name, input int expected, input int actual);
    check_total++;
    if (actual != expected) begin
      $display("FAIL %s: expected %0d, actual %0d", name, expected, actual);
      error_count++;
    end
  endtask

  function automatic ulpi_pkg::ulpi_byte_t make_rx_cmd(input logic [1:0] vbus,
                                                       input logic [1:0] ls);
    ulpi_pkg::rx_cmd_t cmd;
    cmd.unused     = 2'b00;
    cmd.rx_event   = ulpi_pkg::RX_INACTIVE;
    cmd.vbus_state = ulpi_pkg::vbus_state_t'(vbus);
    cmd.linestate  = ls;
    return ulpi_pkg::ulpi_byte_t'(cmd);
  endfunction

  // One PHY bus cycle, from falling edge to falling edge
  task automatic drive_bus_cycle(input logic dir, input logic nxt,
                                 input ulpi_pkg::ulpi_byte_t data);
    ulpi_dir_i = dir;
    ulpi_nxt_i = nxt;
    phy_drive  = dir;
    phy_data   = data;
    @(negedge clock);
  endtask

  task automatic send_s_axis(input ulpi_pkg::ulpi_byte_t pkt [$]);
    logic taken;
    foreach (pkt[i]) begin
      s_axis_tvalid_i = 1'b1;
      s_axis_tdata_i  = pkt[i];
      s_axis_tlast_i  = (i == pkt.size() - 1);
      do begin
        @(posedge clock);
        taken = s_axis_tready_o;
        @(negedge clock);
      end while (!taken);
      s_accept_count++;
    end
    s_axis_tvalid_i = 1'b0;
    s_axis_tlast_i  = 1'b0;
  endtask

  // PHY answers a transmit with nxt and records each byte it latches
  // A nonzero stop count ends early, modelling a bus takeover
  task automatic answer_transmit(input bit random_nxt, input int stop_after);
    logic done;
    done = 1'b0;
    while (ulpi_data_io === 8'h00) begin
      @(negedge clock);
    end
    while (!done) begin
      ulpi_nxt_i = random_nxt ? (($urandom % 2) == 1) : 1'b1;
      @(posedge clock);
      if (ulpi_stp_o) begin
        done = 1'b1;
      end else if (ulpi_nxt_i) begin
        tx_got.push_back(ulpi_data_io);
        done = (stop_after > 0) && (tx_got.size() == stop_after);
      end
      @(negedge clock);
    end
    ulpi_nxt_i = 1'b0;
  endtask

  task automatic run_tx_packet(input string name, input bit random_nxt);
    ulpi_pkg::ulpi_byte_t pkt [$];
    int stp_before;
    int i;
    // OUT-style PID with identifier nibble 1
    pkt.push_back(8'hE1);
    repeat (6) pkt.push_back(ulpi_pkg::ulpi_byte_t'($urandom));
    tx_got.delete();
    s_accept_count = 0;
    stp_before = stp_count;
    fork
      send_s_axis(pkt);
      answer_transmit(random_nxt, 0);
    join
    repeat (2) @(negedge clock);
    check_count({name, " captured bytes"}, 7, tx_got.size());
    check_byte({name, " tx cmd"}, OUT_TXCMD, tx_got[0]);
    for (i = 1; i < 7 && i < tx_got.size(); i++) begin
      check_byte({name, " data"}, pkt[i], tx_got[i]);
    end
    check_count({name, " stp pulses"}, 1, stp_count - stp_before);
    check_count({name, " accepted beats"}, 7, s_accept_count);
  endtask

  task automatic test_rx_cmd();
    logic [1:0] vbus_list [5];
    logic [1:0] ls_list [5];
    int k;
    vbus_list = '{2'd3, 2'd0, 2'd3, 2'd0, 2'd3};
    ls_list   = '{2'b01, 2'b01, 2'b10, 2'b10, 2'b01};
    // Turnaround carries no byte
    drive_bus_cycle(1'b1, 1'b0, 8'h00);
    for (k = 0; k < 5; k++) begin
      drive_bus_cycle(1'b1, 1'b0, make_rx_cmd(vbus_list[k], ls_list[k]));
      check_bit("test_rx_cmd vbus_valid", vbus_list[k] == 2'd3, usb_vbus_valid_o);
      check_bit("test_rx_cmd idle", ls_list[k] == `IDLE_LINESTATE, usb_idle_o);
    end
    drive_bus_cycle(1'b0, 1'b0, 8'h00);
  endtask

  task automatic test_rx_packet();
    ulpi_pkg::ulpi_byte_t pkt [$];
    int len;
    int mid;
    int ovf_before;
    int last_before;
    int i;
    len = 1 + ($urandom % 12);
    mid = (len + 1) / 2;
    for (i = 0; i < len; i++) begin
      pkt.push_back(ulpi_pkg::ulpi_byte_t'($urandom));
    end
    rx_got.delete();
    ovf_before  = overflow_count;
    last_before = rx_last_count;
    m_axis_tready_i = 1'b1;
    drive_bus_cycle(1'b1, 1'b0, 8'h00);
    for (i = 0; i < len; i++) begin
      drive_bus_cycle(1'b1, 1'b1, pkt[i]);
      if (i == mid - 1) begin
        drive_bus_cycle(1'b1, 1'b0, make_rx_cmd(2'd3, `IDLE_LINESTATE));
      end
    end
    drive_bus_cycle(1'b0, 1'b0, 8'h00);
    while (rx_last_count == last_before) begin
      @(negedge clock);
    end
    repeat (2) @(negedge clock);
    check_count("test_rx_packet beats", len, rx_got.size());
    for (i = 0; i < len && i < rx_got.size(); i++) begin
      check_byte("test_rx_packet data", pkt[i], rx_got[i].data);
      check_bit("test_rx_packet last", i == len - 1, rx_got[i].last);
    end
    check_count("test_rx_packet overflow pulses", 0, overflow_count - ovf_before);
  endtask

  task automatic test_rx_backpressure();
    ulpi_pkg::ulpi_byte_t pkt [$];
    int ovf_before;
    int i;
    for (i = 0; i < BP_BYTES; i++) begin
      pkt.push_back(ulpi_pkg::ulpi_byte_t'($urandom));
    end
    rx_got.delete();
    ovf_before = overflow_count;
    m_axis_tready_i = 1'b0;
    drive_bus_cycle(1'b1, 1'b0, 8'h00);
    for (i = 0; i < BP_BYTES; i++) begin
      drive_bus_cycle(1'b1, 1'b1, pkt[i]);
    end
    drive_bus_cycle(1'b0, 1'b0, 8'h00);
    repeat (3) @(negedge clock);
    check_count("test_rx_backpressure overflow pulses", BP_BYTES - `RX_FIFO_DEPTH,
                overflow_count - ovf_before);
    check_count("test_rx_backpressure beats while stalled", 0, rx_got.size());
    m_axis_tready_i = 1'b1;
    while (rx_got.size() < `RX_FIFO_DEPTH) begin
      @(negedge clock);
    end
    repeat (4) @(negedge clock);
    check_count("test_rx_backpressure beats", `RX_FIFO_DEPTH, rx_got.size());
    check_bit("test_rx_backpressure tvalid after drain", 1'b0, m_axis_tvalid_o);
    for (i = 0; i < `RX_FIFO_DEPTH; i++) begin
      check_byte("test_rx_backpressure data", pkt[i], rx_got[i].data);
      check_bit("test_rx_backpressure last", 1'b0, rx_got[i].last);
    end
  endtask

  task automatic test_tx_abort();
    ulpi_pkg::ulpi_byte_t pkt [$];
    int stp_before;
    pkt.push_back(8'hE1);
    repeat (6) pkt.push_back(ulpi_pkg::ulpi_byte_t'($urandom));
    tx_got.delete();
    s_accept_count = 0;
    stp_before = stp_count;
    fork
      send_s_axis(pkt);
      begin
        // TX CMD and two data bytes, then the PHY takes the bus
        answer_transmit(1'b0, 3);
        repeat (3) drive_bus_cycle(1'b1, 1'b0, make_rx_cmd(2'd3, `IDLE_LINESTATE));
        drive_bus_cycle(1'b0, 1'b0, 8'h00);
      end
    join
    repeat (2) @(negedge clock);
    check_count("test_tx_abort captured bytes", 3, tx_got.size());
    check_byte("test_tx_abort tx cmd", OUT_TXCMD, tx_got[0]);
    check_byte("test_tx_abort data", pkt[1], tx_got[1]);
    check_byte("test_tx_abort data", pkt[2], tx_got[2]);
    check_count("test_tx_abort stp pulses", 0, stp_count - stp_before);
    check_count("test_tx_abort accepted beats", 7, s_accept_count);
    run_tx_packet("test_tx_abort next packet", 1'b0);
  endtask

  initial begin : watchdog
    #(TOTAL_CYCLES * CLK_PERIOD_NS * 3);
    $display("Watchdog expired: the run hung and was stopped");
    $display("Test failed");
    $finish;
  end

  initial begin
    void'($urandom(39));
    clock           = 1'b0;
    areset_n        = 1'b0;
    ulpi_dir_i      = 1'b0;
    ulpi_nxt_i      = 1'b0;
    phy_drive       = 1'b0;
    phy_data        = 8'h00;
    s_axis_tvalid_i = 1'b0;
    s_axis_tlast_i  = 1'b0;
    s_axis_tdata_i  = 8'h00;
    m_axis_tready_i = 1'b0;
    error_count     = 0;
    check_total     = 0;
    assert_failures = 0;
    overflow_count  = 0;
    stp_count       = 0;
    rx_last_count   = 0;
    s_accept_count  = 0;

    repeat (2) @(negedge clock);
    check_bit("reset ulpi_reset_o", 1'b1, ulpi_reset_o);
    areset_n = 1'b1;
    while (ulpi_reset_o) begin
      @(negedge clock);
    end
    check_bit("reset ulpi_stp_o", 1'b0, ulpi_stp_o);
    check_bit("reset s_axis_tready_o", 1'b0, s_axis_tready_o);
    check_bit("reset m_axis_tvalid_o", 1'b0, m_axis_tvalid_o);
    check_bit("reset ulpi_rx_overflow_o", 1'b0, ulpi_rx_overflow_o);
    check_bit("reset usb_vbus_valid_o", 1'b0, usb_vbus_valid_o);
    check_bit("reset usb_idle_o", 1'b0, usb_idle_o);

    test_rx_cmd();
    test_rx_packet();
    test_rx_backpressure();
    run_tx_packet("test_tx_packet", 1'b0);
    run_tx_packet("test_tx_nxt_stall", 1'b1);
    test_tx_abort();

    assert_failures = ulpi_axis_inst.ulpi_axis_properties_inst.fail_count;
    $display("Errors: %0d of %0d checks, %0d assertion failures",
             error_count, check_total, assert_failures);
    if (error_count == 0 && assert_failures == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+include
logic/ulpi_pkg.sv
logic/byte_stream_if.sv
logic/beat_fifo.sv
logic/ulpi_rx.sv
logic/ulpi_tx.sv
logic/ulpi_axis.sv
bench/ulpi_axis_properties.sv
bench/ulpi_axis_tb.sv

/* include/ulpi_settings.svh */
`ifndef ULPI_SETTINGS_SVH
`define ULPI_SETTINGS_SVH

// Receive buffer depth in beats
// The PHY cannot be stalled, so this bounds a burst from the host
`define RX_FIFO_DEPTH 16

// Upper nibble of a transmit command byte
// The low nibble carries the packet identifier
`define TXCMD_PREFIX 4'b0100

// Line state reported by the PHY when the bus is idle
// Full speed J state, as seen in an RX CMD
`define IDLE_LINESTATE 2'b01

`endif

/* logic/beat_fifo.sv */
`timescale 1ns/1ps
`default_nettype none
`include "ulpi_settings.svh"

module beat_fifo (
  input wire            clock,
  input wire            areset_n,
  byte_stream_if.sink   wr_i,
  byte_stream_if.source rd_o,
  output logic          full_o
);

  localparam int DEPTH = `RX_FIFO_DEPTH;
  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  ulpi_pkg::beat_t mem [DEPTH];
  ulpi_pkg::beat_t head;

  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   count;
  logic          do_write;
  logic          do_read;

  assign do_write = wr_i.valid && wr_i.ready;
  assign do_read  = rd_o.valid && rd_o.ready;

  // Storage array
  always_ff @(posedge clock) begin
    if (do_write) begin
      mem[wr_ptr] <= '{last: wr_i.last, data: wr_i.data};
    end
  end

  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_write) begin
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_read) begin
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Occupancy only moves when exactly one side transfers
      case ({do_write, do_read})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign full_o     = (count == (AW + 1)'(DEPTH));
  assign wr_i.ready = !full_o;

  // Oldest beat sits at the read pointer
  // It stays put until the sink takes it
  assign head       = mem[rd_ptr];
  assign rd_o.valid = (count != '0);
  assign rd_o.data  = head.data;
  assign rd_o.last  = head.last;

endmodule

`default_nettype wire

/* logic/byte_stream_if.sv */
`timescale 1ns/1ps
`default_nettype none

// Byte stream with a last-byte marker
// A beat moves on a rising clock when valid and ready are both high
interface byte_stream_if;

  logic                 valid;
  logic                 ready;
  logic                 last;
  ulpi_pkg::ulpi_byte_t data;

  modport source (
    output valid,
    output last,
    output data,
    input  ready
  );

  modport sink (
    input  valid,
    input  last,
    input  data,
    output ready
  );

endinterface

`default_nettype wire

/* logic/ulpi_axis.sv */
`timescale 1ns/1ps
`default_nettype none

module ulpi_axis (
  input wire                        clock,
  input wire                        areset_n,

  // ULPI PHY
  output logic                      ulpi_reset_o,
  output logic                      ulpi_stp_o,
  input wire                        ulpi_dir_i,
  input wire                        ulpi_nxt_i,
  inout wire [7:0]                  ulpi_data_io,

  // Status
  output logic                      usb_vbus_valid_o,
  output logic                      usb_idle_o,
  output logic                      ulpi_rx_overflow_o,

  // Transmit stream, toward the host
  input wire                        s_axis_tvalid_i,
  input wire                        s_axis_tlast_i,
  input wire ulpi_pkg::ulpi_byte_t  s_axis_tdata_i,
  output logic                      s_axis_tready_o,

  // Receive stream, from the host
  output logic                      m_axis_tvalid_o,
  output logic                      m_axis_tlast_o,
  output ulpi_pkg::ulpi_byte_t      m_axis_tdata_o,
  input wire                        m_axis_tready_i
);

  logic [1:0]           rst_sync;
  logic                 rst_n;
  logic                 rx_fifo_full;
  ulpi_pkg::ulpi_byte_t tx_data;
  ulpi_pkg::ulpi_byte_t bus_data;

  byte_stream_if rx_wr ();
  byte_stream_if rx_rd ();

  // Assert at once, release after two edges
  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      rst_sync <= 2'b00;
    end else begin
      rst_sync <= {rst_sync[0], 1'b1};
    end
  end

  assign rst_n        = rst_sync[1];
  assign ulpi_reset_o = !rst_n;

  // Link drives the bus only while the PHY leaves it to us
  assign ulpi_data_io = ulpi_dir_i ? 8'hzz : tx_data;
  assign bus_data     = ulpi_data_io;

  ulpi_rx u_rx (
    .clock        (clock),
    .areset_n     (rst_n),
    .ulpi_dir_i   (ulpi_dir_i),
    .ulpi_nxt_i   (ulpi_nxt_i),
    .ulpi_data_i  (bus_data),
    .fifo_full_i  (rx_fifo_full),
    .rx_wr_o      (rx_wr.source),
    .vbus_valid_o (usb_vbus_valid_o),
    .line_idle_o  (usb_idle_o),
    .overflow_o   (ulpi_rx_overflow_o)
  );

  beat_fifo u_rx_fifo (
    .clock    (clock),
    .areset_n (rst_n),
    .wr_i     (rx_wr.sink),
    .rd_o     (rx_rd.source),
    .full_o   (rx_fifo_full)
  );

  ulpi_tx u_tx (
    .clock       (clock),
    .areset_n    (rst_n),
    .ulpi_dir_i  (ulpi_dir_i),
    .ulpi_nxt_i  (ulpi_nxt_i),
    .s_tvalid_i  (s_axis_tvalid_i),
    .s_tlast_i   (s_axis_tlast_i),
    .s_tdata_i   (s_axis_tdata_i),
    .s_tready_o  (s_axis_tready_o),
    .ulpi_data_o (tx_data),
    .ulpi_stp_o  (ulpi_stp_o)
  );

  assign m_axis_tvalid_o = rx_rd.valid;
  assign m_axis_tlast_o  = rx_rd.last;
  assign m_axis_tdata_o  = rx_rd.data;
  assign rx_rd.ready     = m_axis_tready_i;

endmodule

`default_nettype wire

/* logic/ulpi_pkg.sv */
`default_nettype none

package ulpi_pkg;

  // One byte on the ULPI data bus
  typedef logic [7:0] ulpi_byte_t;

  typedef logic [1:0] linestate_t;

  // VBUS comparator levels as reported in an RX CMD
  typedef enum logic [1:0] {
    VBUS_OFF        = 2'd0,
    VBUS_SESS_END   = 2'd1,
    VBUS_SESS_VALID = 2'd2,
    VBUS_VALID      = 2'd3
  } vbus_state_t;

  typedef enum logic [1:0] {
    RX_INACTIVE = 2'd0,
    RX_ACTIVE   = 2'd1,
    RX_ERROR    = 2'd3
  } rx_event_t;

  // Field order follows the RX CMD bit layout, MSB first
  typedef struct packed {
    logic [1:0]  unused;
    rx_event_t   rx_event;
    vbus_state_t vbus_state;
    linestate_t  linestate;
  } rx_cmd_t;

  typedef struct packed {
    logic       last;
    ulpi_byte_t data;
  } beat_t;

endpackage

`default_nettype wire

/* logic/ulpi_rx.sv */
`timescale 1ns/1ps
`default_nettype none
`include "ulpi_settings.svh"

module ulpi_rx (
  input wire                        clock,
  input wire                        areset_n,
  input wire                        ulpi_dir_i,
  input wire                        ulpi_nxt_i,
  input wire ulpi_pkg::ulpi_byte_t  ulpi_data_i,
  input wire                        fifo_full_i,
  byte_stream_if.source             rx_wr_o,
  output logic                      vbus_valid_o,
  output logic                      line_idle_o,
  output logic                      overflow_o
);

  logic dir_q;
  logic bus_owned;
  logic cmd_cycle;
  logic data_cycle;
  logic dir_fall;

  ulpi_pkg::rx_cmd_t    rx_cmd;
  ulpi_pkg::ulpi_byte_t pending_data;
  logic                 pending_valid;

  // First dir-high cycle is the turnaround and carries nothing
  assign bus_owned  = ulpi_dir_i && dir_q;
  assign cmd_cycle  = bus_owned && !ulpi_nxt_i;
  assign data_cycle = bus_owned && ulpi_nxt_i;
  assign dir_fall   = !ulpi_dir_i && dir_q;

  assign rx_cmd = ulpi_pkg::rx_cmd_t'(ulpi_data_i);

  // The pending byte goes out when the next one arrives
  // or, marked as last, when the PHY hands the bus back
  assign rx_wr_o.valid = pending_valid && (data_cycle || dir_fall);
  assign rx_wr_o.last  = dir_fall;
  assign rx_wr_o.data  = pending_data;

  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      dir_q         <= 1'b0;
      pending_valid <= 1'b0;
    end else begin
      dir_q <= ulpi_dir_i;
      if (data_cycle) begin
        pending_valid <= 1'b1;
      end else if (dir_fall) begin
        pending_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (data_cycle) begin
      pending_data <= ulpi_data_i;
    end
  end

  // Status levels from the most recent RX CMD
  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      vbus_valid_o <= 1'b0;
      line_idle_o  <= 1'b0;
    end else if (cmd_cycle) begin
      vbus_valid_o <= (rx_cmd.vbus_state == ulpi_pkg::VBUS_VALID);
      line_idle_o  <= (rx_cmd.linestate == `IDLE_LINESTATE);
    end
  end

  // A write into a full FIFO loses the beat
  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      overflow_o <= 1'b0;
    end else begin
      overflow_o <= rx_wr_o.valid && fifo_full_i;
    end
  end

endmodule

`default_nettype wire

/* logic/ulpi_tx.sv */
`timescale 1ns/1ps
`default_nettype none
`include "ulpi_settings.svh"

module ulpi_tx (
  input wire                        clock,
  input wire                        areset_n,
  input wire                        ulpi_dir_i,
  input wire                        ulpi_nxt_i,
  input wire                        s_tvalid_i,
  input wire                        s_tlast_i,
  input wire ulpi_pkg::ulpi_byte_t  s_tdata_i,
  output logic                      s_tready_o,
  output ulpi_pkg::ulpi_byte_t      ulpi_data_o,
  output logic                      ulpi_stp_o
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_CMD,
    ST_DATA,
    ST_STOP,
    ST_DISCARD
  } state_t;

  state_t               state;
  state_t               state_next;
  ulpi_pkg::ulpi_byte_t txcmd_q;
  logic                 take;

  // PHY latches the bus byte only while the link owns the bus
  assign take = ulpi_nxt_i && !ulpi_dir_i;

  always_comb begin
    state_next = state;
    case (state)
      ST_IDLE: begin
        if (!ulpi_dir_i && s_tvalid_i) begin
          state_next = ST_CMD;
        end
      end
      ST_CMD: begin
        // PID leaves s_axis together with the TX CMD
        if (ulpi_dir_i) begin
          state_next = ST_DISCARD;
        end else if (ulpi_nxt_i) begin
          state_next = s_tlast_i ? ST_STOP : ST_DATA;
        end
      end
      ST_DATA: begin
        if (ulpi_dir_i) begin
          state_next = ST_DISCARD;
        end else if (ulpi_nxt_i && s_tvalid_i && s_tlast_i) begin
          state_next = ST_STOP;
        end
      end
      ST_STOP: begin
        state_next = ST_IDLE;
      end
      ST_DISCARD: begin
        // Drain the abandoned packet up to its last beat
        if (s_tvalid_i && s_tready_o && s_tlast_i) begin
          state_next = ST_IDLE;
        end
      end
      default: begin
        state_next = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      state <= ST_IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_ff @(posedge clock) begin
    if (state == ST_IDLE && state_next == ST_CMD) begin
      txcmd_q <= {`TXCMD_PREFIX, s_tdata_i[3:0]};
    end
  end

  always_comb begin
    case (state)
      ST_CMD, ST_DATA: s_tready_o = take;
      ST_DISCARD:      s_tready_o = !ulpi_dir_i;
      default:         s_tready_o = 1'b0;
    endcase
  end

  always_comb begin
    case (state)
      ST_CMD:  ulpi_data_o = txcmd_q;
      ST_DATA: ulpi_data_o = s_tdata_i;
      default: ulpi_data_o = '0;
    endcase
  end

  // Stop goes out with a zero data byte
  assign ulpi_stp_o = (state == ST_STOP);

endmodule

`default_nettype wire
